// ==== tb.f ====
+incdir+hw
hw/mem_pkg.sv
hw/pipe_pkg.sv
hw/mem_lsu.sv
hw/mem_bus_arbiter.sv
hw/mem_sram.sv
hw/mem_forward.sv
hw/mem_stage_top.sv
tb/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mem_stage -o sim_mem_stage
./obj_dir/sim_mem_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a pass report"
    exit 1
fi
echo "simulation finished cleanly"

// ==== tb/tb_mem_stage.sv ====
// testbench for mem_stage_top with memory and forwarding models, random ops and fetch arbitration
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module tb_mem_stage;

    localparam int clk_period = 20;
    localparam int n_words    = 16;
    localparam int n_rand     = 120;
    localparam int n_fetch    = 10;
    // a random op may add a word load and a fetch test runs up to 7 ops
    localparam int num_ops    = n_words + 2 * n_rand + 7 * n_fetch;

    logic                  clk;
    logic                  rst_n;
    pipe_pkg::mem_in_t     mem_in;
    pipe_pkg::wb_fwd_t     wb_fwd;
    pipe_pkg::src_regs_t   id_src;
    pipe_pkg::src_regs_t   ex_src;
    logic                  fetch_req;
    logic [`MEM_XLEN-1:0]  fetch_addr;
    pipe_pkg::mem_out_t    mem_out;
    pipe_pkg::fwd_t        fwd_ex;
    pipe_pkg::fwd_t        fwd_id;
    pipe_pkg::stall_t      stall;
    mem_pkg::bus_rsp_t     fetch_rsp;

    integer      seed;
    logic [31:0] model_mem [0:n_words-1];

    mem_stage_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_in     (mem_in),
        .wb_fwd     (wb_fwd),
        .id_src     (id_src),
        .ex_src     (ex_src),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .mem_out    (mem_out),
        .fwd_ex     (fwd_ex),
        .fwd_id     (fwd_id),
        .stall      (stall),
        .fetch_rsp  (fetch_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(num_ops * 10 * clk_period);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation timeout");
    end

    // ====================
    // helpers
    // ====================
    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic [31:0] rnd();
        logic [31:0] v;
        v = $random(seed);
        return v;
    endfunction

    function automatic int size_bytes(input mem_pkg::mem_size_e size);
        case (size)
            mem_pkg::size_byte, mem_pkg::size_byte_u: return 1;
            mem_pkg::size_half, mem_pkg::size_half_u: return 2;
            default:                                  return 4;
        endcase
    endfunction

    // naturally aligned lane for the access size
    function automatic logic [1:0] pick_lane(input mem_pkg::mem_size_e size, input logic [1:0] r);
        case (size_bytes(size))
            1:       return r;
            2:       return {r[1], 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic [31:0] load_expect(input logic [31:0] word, input logic [1:0] lane,
                                                input mem_pkg::mem_size_e size);
        logic [31:0] sh;
        sh = word >> (int'(lane) * 8);
        case (size)
            mem_pkg::size_byte:   return {{24{sh[7]}}, sh[7:0]};
            mem_pkg::size_byte_u: return {24'd0, sh[7:0]};
            mem_pkg::size_half:   return {{16{sh[15]}}, sh[15:0]};
            mem_pkg::size_half_u: return {16'd0, sh[15:0]};
            default:              return sh;
        endcase
    endfunction

    // {hit, value} of one gpr source
    function automatic logic [32:0] gpr_expect(input logic [4:0] rs, input logic [31:0] me_data);
        if (rs == 5'd0) begin
            return '0;
        end
        if (mem_in.write_gpr && mem_in.rd == rs) begin
            return {1'b1, me_data};
        end
        if (wb_fwd.write_gpr && wb_fwd.rd == rs) begin
            return {1'b1, wb_fwd.rd_data};
        end
        return '0;
    endfunction

    function automatic pipe_pkg::fwd_t fwd_expect(input pipe_pkg::src_regs_t src,
                                                  input logic [31:0] me_data);
        pipe_pkg::fwd_t f;
        logic           me_csr;
        logic           wb_csr;
        f = '0;
        {f.rs1_hazard, f.rs1_data} = gpr_expect(src.rs1, me_data);
        {f.rs2_hazard, f.rs2_data} = gpr_expect(src.rs2, me_data);
        me_csr = mem_in.write_csr && mem_in.csr_rd == src.csr_rs;
        wb_csr = wb_fwd.write_csr && wb_fwd.csr_rd == src.csr_rs;
        f.csr_hazard = me_csr | wb_csr;
        f.csr_data   = me_csr ? mem_in.csr_out : (wb_csr ? wb_fwd.csr_data : 32'd0);
        return f;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // random pass-through fields, wb bundle and source registers
    task automatic randomize_side();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = rnd();
        r2 = rnd();
        mem_in            = '0;
        mem_in.commit     = r1[0];
        mem_in.pc         = rnd();
        mem_in.inst       = rnd();
        mem_in.alu_out    = rnd();
        mem_in.csr_out    = rnd();
        mem_in.rs2_data   = rnd();
        mem_in.rd         = {3'b000, r1[2:1]};
        mem_in.csr_rd     = r1[4:3];
        mem_in.write_gpr  = r1[5];
        mem_in.write_csr  = r1[6];
        mem_in.halt       = r1[7];
        mem_in.op_valid   = r1[8];
        mem_in.alu_valid  = r1[9];
        mem_in.size       = mem_pkg::size_word;
        wb_fwd.rd         = {3'b000, r1[11:10]};
        wb_fwd.csr_rd     = r1[13:12];
        wb_fwd.write_gpr  = r1[14];
        wb_fwd.write_csr  = r1[15];
        wb_fwd.rd_data    = rnd();
        wb_fwd.csr_data   = rnd();
        id_src = {3'b000, r2[1:0], 3'b000, r2[3:2], r2[5:4]};
        ex_src = {3'b000, r2[7:6], 3'b000, r2[9:8], r2[11:10]};
    endtask

    task automatic verify_outputs(input logic [31:0] me_data);
        check_val("pass_data", 128'({mem_in.pc, mem_in.inst, mem_in.alu_out, mem_in.csr_out}),
                  128'({mem_out.pc, mem_out.inst, mem_out.alu_out, mem_out.csr_out}));
        check_val("pass_ctrl",
                  128'({mem_in.commit, mem_in.rd, mem_in.csr_rd, mem_in.write_gpr,
                        mem_in.write_csr, mem_in.mem_to_reg, mem_in.halt, mem_in.op_valid,
                        mem_in.alu_valid}),
                  128'({mem_out.commit, mem_out.rd, mem_out.csr_rd, mem_out.write_gpr,
                        mem_out.write_csr, mem_out.mem_to_reg, mem_out.halt, mem_out.op_valid,
                        mem_out.alu_valid}));
        check_val("fwd_ex", 128'(fwd_expect(ex_src, me_data)), 128'(fwd_ex));
        check_val("fwd_id", 128'(fwd_expect(id_src, me_data)), 128'(fwd_id));
    endtask

    // ====================
    // operations
    // ====================
    task automatic alu_cycle();
        step();
        randomize_side();
        @(negedge clk);
        check_val("alu_stall", 128'(4'h0), 128'(stall));
        verify_outputs(mem_in.alu_out);
    endtask

    task automatic store_access(input mem_pkg::mem_size_e size, input logic [3:0] idx,
                                input logic [1:0] lane, input logic [31:0] data,
                                input logic raise_fetch, input logic [3:0] fetch_idx);
        step();
        randomize_side();
        if (raise_fetch) begin
            fetch_req  = 1'b1;
            fetch_addr = {26'd0, fetch_idx, 2'b00};
        end
        mem_in.write_mem = 1'b1;
        mem_in.size      = size;
        mem_in.alu_out   = {26'd0, idx, lane};
        mem_in.rs2_data  = data;
        @(negedge clk);
        check_val("store_stall", 128'(4'h0), 128'(stall));
        verify_outputs(mem_in.alu_out);
        for (int k = 0; k < size_bytes(size); k++) begin
            model_mem[idx][(int'(lane) + k) * 8 +: 8] = data[k * 8 +: 8];
        end
    endtask

    task automatic load_access(input mem_pkg::mem_size_e size, input logic [3:0] idx,
                               input logic [1:0] lane);
        int          cycles;
        logic [31:0] exp;
        step();
        randomize_side();
        mem_in.mem_to_reg = 1'b1;
        mem_in.size       = size;
        mem_in.alu_out    = {26'd0, idx, lane};
        @(negedge clk);
        check_val("load_stall_first", 128'(4'hf), 128'(stall));
        cycles = 1;
        while (stall != 4'h0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 8) begin
                $display("load at word %0d never released the stall", idx);
                stop_run();
            end
        end
        check_val("load_cycles", 128'(2), 128'(cycles));
        exp = load_expect(model_mem[idx], lane, size);
        check_val("load_rdata", 128'(exp), 128'(mem_out.rdata));
        verify_outputs(exp);
    endtask

    // fetch raised during a burst of stores and granted in the first free cycle
    task automatic fetch_test();
        logic [31:0]        r;
        logic [3:0]         fidx;
        mem_pkg::mem_size_e sz;
        int                 n;
        r    = rnd();
        fidx = r[3:0];
        n    = 1 + int'(r[5:4]);
        for (int k = 0; k < n; k++) begin
            r  = rnd();
            sz = mem_pkg::mem_size_e'(3'(r % 32'd5));
            store_access(sz, r[7:4], pick_lane(sz, r[9:8]), rnd(), k == 0, fidx);
            check_val("fetch_wait", 128'(1'b0), 128'(fetch_rsp.rvalid));
        end
        alu_cycle();
        check_val("fetch_free_cycle", 128'(1'b0), 128'(fetch_rsp.rvalid));
        step();
        fetch_req = 1'b0;
        @(negedge clk);
        check_val("fetch_rvalid", 128'(1'b1), 128'(fetch_rsp.rvalid));
        check_val("fetch_rdata", 128'(model_mem[fidx]), 128'(fetch_rsp.rdata));
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        logic [31:0]        r;
        mem_pkg::mem_size_e sz;
        seed       = 32'hf64d_0866;
        clk        = 1'b0;
        rst_n      = 1'b0;
        mem_in     = '0;
        wb_fwd     = '0;
        id_src     = '0;
        ex_src     = '0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("reset_stall", 128'(4'h0), 128'(stall));
        check_val("reset_fetch_rvalid", 128'(1'b0), 128'(fetch_rsp.rvalid));

        // known contents for every modeled word
        for (int i = 0; i < n_words; i++) begin
            store_access(mem_pkg::size_word, 4'(i), 2'b00, rnd(), 1'b0, 4'd0);
        end

        for (int i = 0; i < n_rand; i++) begin
            r  = rnd();
            sz = mem_pkg::mem_size_e'(3'(r % 32'd5));
            case (r[11:10])
                2'd0: begin
                    store_access(sz, r[7:4], pick_lane(sz, r[9:8]), rnd(), 1'b0, 4'd0);
                    if (size_bytes(sz) != 4) begin
                        load_access(mem_pkg::size_word, r[7:4], 2'b00);
                    end
                end
                2'd3:    alu_cycle();
                default: load_access(sz, r[7:4], pick_lane(sz, r[9:8]));
            endcase
        end

        for (int i = 0; i < n_fetch; i++) begin
            fetch_test();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== hw/mem_stage_top.sv ====
// memory stage top: lsu, arbiter, data SRAM, forwarding, writeback bundle
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::mem_in_t     mem_in,
    input  pipe_pkg::wb_fwd_t     wb_fwd,
    input  pipe_pkg::src_regs_t   id_src,
    input  pipe_pkg::src_regs_t   ex_src,
    input  logic                  fetch_req,
    input  logic [`MEM_XLEN-1:0]  fetch_addr,
    output pipe_pkg::mem_out_t    mem_out,
    output pipe_pkg::fwd_t        fwd_ex,
    output pipe_pkg::fwd_t        fwd_id,
    output pipe_pkg::stall_t      stall,
    output mem_pkg::bus_rsp_t     fetch_rsp
);

    mem_pkg::bus_req_t     lsu_req;
    mem_pkg::bus_rsp_t     lsu_rsp;
    mem_pkg::bus_req_t     fetch_req_bus;
    mem_pkg::bus_req_t     sram_req;
    logic                  lsu_gnt;
    logic [`MEM_XLEN-1:0]  sram_rdata;
    logic [`MEM_XLEN-1:0]  load_data;
    logic                  ldst_busy;
    logic                  ld_done;

    // fetch is a read-only word port
    always_comb begin
        fetch_req_bus      = '0;
        fetch_req_bus.req  = fetch_req;
        fetch_req_bus.be   = '1;
        fetch_req_bus.addr = fetch_addr;
    end

    // ====================
    // writeback bundle
    // ====================
    always_comb begin
        mem_out.commit     = mem_in.commit;
        mem_out.pc         = mem_in.pc;
        mem_out.inst       = mem_in.inst;
        mem_out.alu_out    = mem_in.alu_out;
        mem_out.csr_out    = mem_in.csr_out;
        // zero until the load returns
        mem_out.rdata      = ld_done ? load_data : '0;
        mem_out.rd         = mem_in.rd;
        mem_out.csr_rd     = mem_in.csr_rd;
        mem_out.write_gpr  = mem_in.write_gpr;
        mem_out.write_csr  = mem_in.write_csr;
        mem_out.mem_to_reg = mem_in.mem_to_reg;
        mem_out.halt       = mem_in.halt;
        mem_out.op_valid   = mem_in.op_valid;
        mem_out.alu_valid  = mem_in.alu_valid;
    end

    mem_lsu mem_lsu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_in    (mem_in),
        .lsu_gnt   (lsu_gnt),
        .lsu_rsp   (lsu_rsp),
        .lsu_req   (lsu_req),
        .load_data (load_data),
        .ldst_busy (ldst_busy),
        .ld_done   (ld_done)
    );

    mem_bus_arbiter mem_bus_arbiter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .lsu_req       (lsu_req),
        .fetch_req_bus (fetch_req_bus),
        .sram_rdata    (sram_rdata),
        .lsu_gnt       (lsu_gnt),
        .lsu_rsp       (lsu_rsp),
        .fetch_rsp     (fetch_rsp),
        .sram_req      (sram_req)
    );

    mem_sram mem_sram_inst (
        .clk        (clk),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata)
    );

    mem_forward mem_forward_inst (
        .mem_in    (mem_in),
        .wb_fwd    (wb_fwd),
        .id_src    (id_src),
        .ex_src    (ex_src),
        .load_data (load_data),
        .ldst_busy (ldst_busy),
        .fwd_ex    (fwd_ex),
        .fwd_id    (fwd_id),
        .stall     (stall)
    );

endmodule

// ==== hw/mem_forward.sv ====
// forwarding muxes, hazard flags and stall generation
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_forward (
    input  pipe_pkg::mem_in_t     mem_in,
    input  pipe_pkg::wb_fwd_t     wb_fwd,
    input  pipe_pkg::src_regs_t   id_src,
    input  pipe_pkg::src_regs_t   ex_src,
    input  logic [`MEM_XLEN-1:0]  load_data,
    input  logic                  ldst_busy,
    output pipe_pkg::fwd_t        fwd_ex,
    output pipe_pkg::fwd_t        fwd_id,
    output pipe_pkg::stall_t      stall
);

    logic [`MEM_XLEN-1:0] mem_gpr_data;

    // {hit, data} for one gpr source, MEM before WB, x0 never matches
    function automatic logic [`MEM_XLEN:0] pick_gpr(
        input logic [`MEM_GPR_IDX_W-1:0]  rs,
        input pipe_pkg::mem_in_t          me,
        input logic [`MEM_XLEN-1:0]       me_data,
        input pipe_pkg::wb_fwd_t          wb
    );
        logic [`MEM_XLEN:0] res;
        res = '0;
        if (rs != '0) begin
            if (me.write_gpr && me.rd == rs) begin
                res = {1'b1, me_data};
            end else if (wb.write_gpr && wb.rd == rs) begin
                res = {1'b1, wb.rd_data};
            end
        end
        return res;
    endfunction

    function automatic pipe_pkg::fwd_t resolve(
        input pipe_pkg::src_regs_t  src,
        input pipe_pkg::mem_in_t    me,
        input logic [`MEM_XLEN-1:0] me_data,
        input pipe_pkg::wb_fwd_t    wb
    );
        pipe_pkg::fwd_t f;
        f = '0;
        {f.rs1_hazard, f.rs1_data} = pick_gpr(src.rs1, me, me_data, wb);
        {f.rs2_hazard, f.rs2_data} = pick_gpr(src.rs2, me, me_data, wb);
        // csr index 0 is a real csr
        if (me.write_csr && me.csr_rd == src.csr_rs) begin
            f.csr_hazard = 1'b1;
            f.csr_data   = me.csr_out;
        end else if (wb.write_csr && wb.csr_rd == src.csr_rs) begin
            f.csr_hazard = 1'b1;
            f.csr_data   = wb.csr_data;
        end
        return f;
    endfunction

    // ====================
    // outputs
    // ====================
    assign mem_gpr_data = mem_in.mem_to_reg ? load_data : mem_in.alu_out;

    assign fwd_ex = resolve(ex_src, mem_in, mem_gpr_data, wb_fwd);
    assign fwd_id = resolve(id_src, mem_in, mem_gpr_data, wb_fwd);

    // whole front end waits on the data bus
    assign stall = '{stall_if: ldst_busy, stall_id: ldst_busy,
                     stall_ex: ldst_busy, stall_me: ldst_busy};

endmodule

// ==== hw/mem_sram.sv ====
// byte-writable single-port data SRAM, one-cycle read
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_sram (
    input  logic                  clk,
    input  mem_pkg::bus_req_t     sram_req,
    output logic [`MEM_XLEN-1:0]  sram_rdata
);

    logic [`MEM_XLEN-1:0]        mem_array [0:(1 << `MEM_DEPTH_LOG2)-1];
    logic [`MEM_XLEN-1:0]        rdata_q;
    logic [`MEM_DEPTH_LOG2-1:0]  word_idx;

    // byte address to word index
    assign word_idx = sram_req.addr[`MEM_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (sram_req.req) begin
            if (sram_req.we) begin
                for (int i = 0; i < `MEM_XLEN/8; i++) begin
                    if (sram_req.be[i]) begin
                        mem_array[word_idx][i*8 +: 8] <= sram_req.wdata[i*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_array[word_idx];
            end
        end
    end

    // holds until the next read
    assign sram_rdata = rdata_q;

endmodule

// ==== hw/mem_bus_arbiter.sv ====
// fixed-priority arbiter between load/store unit and fetch port
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_bus_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pkg::bus_req_t     lsu_req,
    input  mem_pkg::bus_req_t     fetch_req_bus,
    input  logic [`MEM_XLEN-1:0]  sram_rdata,
    output logic                  lsu_gnt,
    output mem_pkg::bus_rsp_t     lsu_rsp,
    output mem_pkg::bus_rsp_t     fetch_rsp,
    output mem_pkg::bus_req_t     sram_req
);

    logic fetch_gnt;
    logic lsu_rd_q;
    logic fetch_rd_q;

    // load/store always wins
    assign lsu_gnt   = lsu_req.req;
    assign fetch_gnt = fetch_req_bus.req & ~lsu_req.req;

    always_comb begin
        sram_req = '0;
        if (lsu_gnt) begin
            sram_req = lsu_req;
        end else if (fetch_gnt) begin
            sram_req = fetch_req_bus;
        end
    end

    // ====================
    // read return
    // ====================
    // remember who owns next cycle's rdata
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_rd_q   <= 1'b0;
            fetch_rd_q <= 1'b0;
        end else begin
            lsu_rd_q   <= lsu_gnt & ~lsu_req.we;
            fetch_rd_q <= fetch_gnt & ~fetch_req_bus.we;
        end
    end

    assign lsu_rsp   = '{rvalid: lsu_rd_q, rdata: sram_rdata};
    assign fetch_rsp = '{rvalid: fetch_rd_q, rdata: sram_rdata};

    // a waiting fetch keeps its request up
    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_bus.req && !fetch_gnt |=> fetch_req_bus.req);

endmodule

// ==== hw/mem_lsu.sv ====
// load/store unit: bus request, byte lanes, load extension
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_lsu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::mem_in_t     mem_in,
    input  logic                  lsu_gnt,
    input  mem_pkg::bus_rsp_t     lsu_rsp,
    output mem_pkg::bus_req_t     lsu_req,
    output logic [`MEM_XLEN-1:0]  load_data,
    output logic                  ldst_busy,
    output logic                  ld_done
);

    logic                  ld_granted_q;
    logic                  wready;
    logic [1:0]            lane;
    logic [`MEM_XLEN-1:0]  lane_data;

    assign lane = mem_in.alu_out[1:0];

    // ====================
    // request
    // ====================
    always_comb begin
        lsu_req       = '0;
        lsu_req.req   = mem_in.write_mem | (mem_in.mem_to_reg & ~ld_granted_q);
        lsu_req.we    = mem_in.write_mem;
        lsu_req.addr  = mem_in.alu_out;
        // store data moved up to its byte lane
        lsu_req.wdata = mem_in.rs2_data << {lane, 3'b000};
        case (mem_in.size)
            mem_pkg::size_byte, mem_pkg::size_byte_u: lsu_req.be = 4'b0001 << lane;
            mem_pkg::size_half, mem_pkg::size_half_u: lsu_req.be = 4'b0011 << lane;
            default:                                  lsu_req.be = 4'b1111;
        endcase
    end

    // load granted, wait for rvalid without asking again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_granted_q <= 1'b0;
        end else if (ld_done) begin
            ld_granted_q <= 1'b0;
        end else if (lsu_gnt && !lsu_req.we) begin
            ld_granted_q <= 1'b1;
        end
    end

    assign wready    = mem_in.write_mem & lsu_gnt;
    assign ld_done   = ld_granted_q & lsu_rsp.rvalid;
    assign ldst_busy = (mem_in.mem_to_reg & ~ld_done) | (mem_in.write_mem & ~wready);

    // ====================
    // load extension
    // ====================
    assign lane_data = lsu_rsp.rdata >> {lane, 3'b000};

    always_comb begin
        case (mem_in.size)
            mem_pkg::size_byte:   load_data = {{(`MEM_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            mem_pkg::size_byte_u: load_data = {{(`MEM_XLEN-8){1'b0}}, lane_data[7:0]};
            mem_pkg::size_half:   load_data = {{(`MEM_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            mem_pkg::size_half_u: load_data = {{(`MEM_XLEN-16){1'b0}}, lane_data[15:0]};
            default:              load_data = lane_data;
        endcase
    end

    // no misaligned trap here, so the pipeline must not issue one
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req.req |->
            !((mem_in.size inside {mem_pkg::size_half, mem_pkg::size_half_u}) && lane[0]) &&
            !((mem_in.size == mem_pkg::size_word) && (lane != 2'b00)));

    a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_in.mem_to_reg && mem_in.write_mem));

endmodule

// ==== hw/pipe_pkg.sv ====
// pipeline-side types: MEM stage bundles, WB forwarding, source registers, stalls
`include "mem_stage_settings.svh"

package pipe_pkg;

    // ====================
    // EX/MEM register
    // ====================
    typedef struct packed {
        logic                       commit;
        logic [`MEM_XLEN-1:0]       pc;
        logic [`MEM_XLEN-1:0]       inst;
        logic [`MEM_XLEN-1:0]       alu_out;
        logic [`MEM_XLEN-1:0]       csr_out;
        logic [`MEM_GPR_IDX_W-1:0]  rd;
        logic [`MEM_XLEN-1:0]       rs2_data;
        logic [`MEM_CSR_IDX_W-1:0]  csr_rd;
        logic                       write_gpr;
        logic                       write_csr;
        logic                       mem_to_reg;
        logic                       write_mem;
        mem_pkg::mem_size_e         size;
        logic                       halt;
        logic                       op_valid;
        logic                       alu_valid;
    } mem_in_t;

    // towards writeback, store fields dropped
    typedef struct packed {
        logic                       commit;
        logic [`MEM_XLEN-1:0]       pc;
        logic [`MEM_XLEN-1:0]       inst;
        logic [`MEM_XLEN-1:0]       alu_out;
        logic [`MEM_XLEN-1:0]       csr_out;
        logic [`MEM_XLEN-1:0]       rdata;
        logic [`MEM_GPR_IDX_W-1:0]  rd;
        logic [`MEM_CSR_IDX_W-1:0]  csr_rd;
        logic                       write_gpr;
        logic                       write_csr;
        logic                       mem_to_reg;
        logic                       halt;
        logic                       op_valid;
        logic                       alu_valid;
    } mem_out_t;

    // ====================
    // forwarding
    // ====================
    typedef struct packed {
        logic [`MEM_GPR_IDX_W-1:0]  rd;
        logic [`MEM_CSR_IDX_W-1:0]  csr_rd;
        logic                       write_gpr;
        logic                       write_csr;
        logic [`MEM_XLEN-1:0]       rd_data;
        logic [`MEM_XLEN-1:0]       csr_data;
    } wb_fwd_t;

    typedef struct packed {
        logic [`MEM_GPR_IDX_W-1:0]  rs1;
        logic [`MEM_GPR_IDX_W-1:0]  rs2;
        logic [`MEM_CSR_IDX_W-1:0]  csr_rs;
    } src_regs_t;

    typedef struct packed {
        logic [`MEM_XLEN-1:0]       rs1_data;
        logic [`MEM_XLEN-1:0]       rs2_data;
        logic [`MEM_XLEN-1:0]       csr_data;
        logic                       rs1_hazard;
        logic                       rs2_hazard;
        logic                       csr_hazard;
    } fwd_t;

    typedef struct packed {
        logic                       stall_if;
        logic                       stall_id;
        logic                       stall_ex;
        logic                       stall_me;
    } stall_t;

endpackage

// ==== hw/mem_pkg.sv ====
// memory-side types: access size encoding, bus request and bus response
`include "mem_stage_settings.svh"

package mem_pkg;

    // ====================
    // access size
    // ====================
    // the _u variants zero-extend on load
    typedef enum logic [2:0] {
        size_byte   = 3'd0,
        size_half   = 3'd1,
        size_word   = 3'd2,
        size_byte_u = 3'd3,
        size_half_u = 3'd4
    } mem_size_e;

    // ====================
    // bus
    // ====================
    // requester holds req until granted
    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [`MEM_XLEN/8-1:0]   be;
        logic [`MEM_XLEN-1:0]     addr;
        logic [`MEM_XLEN-1:0]     wdata;
    } bus_req_t;

    // rvalid is a one-cycle pulse, one cycle after the read grant
    typedef struct packed {
        logic                     rvalid;
        logic [`MEM_XLEN-1:0]     rdata;
    } bus_rsp_t;

endpackage

// ==== hw/mem_stage_settings.svh ====
// width and depth macros for the memory stage
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// ====================
// datapath
// ====================
`define MEM_XLEN        32

// data SRAM word-address bits
`define MEM_DEPTH_LOG2  10

// ====================
// register indices
// ====================
`define MEM_GPR_IDX_W   5

// short csr index used by the forwarding path
`define MEM_CSR_IDX_W   2

`endif
